// ==== ladybird_pkg.sv ====
`default_nettype none

package ladybird_pkg;

  // ##################################################
  // Address map and field widths
  // ##################################################

  localparam logic [3:0] RAM_REGION    = 4'h8;  // 0x8000_0000 window
  localparam int         BANK_FIELD_W  = 4;
  localparam int         INDEX_FIELD_W = 10;
  localparam int         RSVD_FIELD_W  = 12;    // Bits 27:16, not decoded
  localparam int         DATA_W        = 32;
  localparam int         STRB_W        = DATA_W / 8;

  // ##################################################
  // Bus address, raw word or decoded fields
  // ##################################################

  typedef struct packed {
    logic [3:0]               region;    // 31:28
    logic [RSVD_FIELD_W-1:0]  reserved;  // Ignored by the decoder
    logic [BANK_FIELD_W-1:0]  bank;      // 15:12
    logic [INDEX_FIELD_W-1:0] index;     // Word index, 11:2
    logic [1:0]               byte_off;  // Must be zero
  } addr_fields_t;

  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t fields;
  } bus_addr_u;

  // ##################################################
  // Bus and internal transfer types
  // ##################################################

  // Core side request, one per valid cycle
  typedef struct packed {
    logic              valid;
    logic              we;
    bus_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
  } bus_req_t;

  // Core side response, fixed latency
  typedef struct packed {
    logic              valid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Shared by all banks, qualified by the bank select
  typedef struct packed {
    logic                     we;
    logic [INDEX_FIELD_W-1:0] index;
    logic [DATA_W-1:0]        wdata;
    logic [STRB_W-1:0]        strb;
  } bank_req_t;

  // Decoder to collector bookkeeping
  typedef struct packed {
    logic                    valid;
    logic                    err;
    logic                    is_read;
    logic [BANK_FIELD_W-1:0] bank;
  } rsp_tag_t;

endpackage

`default_nettype wire

// ==== ladybird_addr_decoder.sv ====
`default_nettype none

module ladybird_addr_decoder #(
  parameter int NUM_BANKS   = 4,
  parameter int BANK_ADDR_W = 4
) (
  input  logic                    clk_i,
  input  logic                    anrst_i,
  input  ladybird_pkg::bus_req_t  req_i,
  output ladybird_pkg::bank_req_t bank_req_o,
  output logic [NUM_BANKS-1:0]    bank_sel_o,
  output ladybird_pkg::rsp_tag_t  tag_o
);

  import ladybird_pkg::*;

  bus_addr_u            addr;
  logic                 region_err;
  logic                 bank_err;
  logic                 index_err;
  logic                 align_err;
  logic                 addr_err;
  logic [NUM_BANKS-1:0] sel_next;

  // ##################################################
  // Address checks
  // ##################################################

  assign addr = req_i.addr;

  assign region_err = (addr.fields.region != RAM_REGION);
  assign bank_err   = (int'(addr.fields.bank) >= NUM_BANKS);  // Unpopulated bank
  assign index_err  = ((addr.fields.index >> BANK_ADDR_W) != '0);  // Past bank depth
  assign align_err  = (addr.fields.byte_off != 2'b00);  // Word access only
  assign addr_err   = region_err | bank_err | index_err | align_err;

  // One-hot select, empty for any bad address
  always_comb begin
    sel_next = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      sel_next[b] = ~addr_err & (int'(addr.fields.bank) == b);
    end
  end

  // ##################################################
  // Request stage
  // ##################################################

  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      bank_sel_o <= '0;
      tag_o      <= '0;
    end else begin
      bank_sel_o    <= req_i.valid ? sel_next : '0;
      tag_o.valid   <= req_i.valid;
      tag_o.err     <= req_i.valid & addr_err;
      tag_o.is_read <= req_i.valid & ~req_i.we;
      tag_o.bank    <= addr.fields.bank;  // Only meaningful without error
    end
  end

  // Broadcast payload, banks ignore it unless selected
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      bank_req_o.we    <= req_i.we;
      bank_req_o.index <= addr.fields.index;
      bank_req_o.wdata <= req_i.wdata;
      bank_req_o.strb  <= req_i.strb;
    end
  end

endmodule

`default_nettype wire

// ==== ladybird_ram_bank.sv ====
`default_nettype none

module ladybird_ram_bank #(
  parameter int BANK_ADDR_W = 4
) (
  input  logic                            clk_i,
  input  logic                            anrst_i,
  input  logic                            sel_i,
  input  ladybird_pkg::bank_req_t         bank_req_i,
  output logic [ladybird_pkg::DATA_W-1:0] rdata_o
);

  import ladybird_pkg::*;

  localparam int DEPTH = 2 ** BANK_ADDR_W;

  logic [DATA_W-1:0]      mem [DEPTH];
  logic [BANK_ADDR_W-1:0] word_idx;

  // Upper index bits are already checked to be zero
  assign word_idx = bank_req_i.index[BANK_ADDR_W-1:0];

  // ##################################################
  // Storage and registered read port
  // ##################################################

  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      for (int w = 0; w < DEPTH; w++) begin
        mem[w] <= '0;  // Banks start out zeroed
      end
      rdata_o <= '0;
    end else if (sel_i) begin
      if (bank_req_i.we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (bank_req_i.strb[b]) begin
            mem[word_idx][8*b +: 8] <= bank_req_i.wdata[8*b +: 8];  // Strobed lane
          end
        end
      end else begin
        rdata_o <= mem[word_idx];
      end
    end
  end

  // Output holds its value between reads, the collector only
  // samples it in the cycle after this bank was selected for a read

endmodule

`default_nettype wire

// ==== ladybird_resp_collector.sv ====
`default_nettype none

module ladybird_resp_collector #(
  parameter int NUM_BANKS = 4
) (
  input  logic                                           clk_i,
  input  logic                                           anrst_i,
  input  ladybird_pkg::rsp_tag_t                         tag_i,
  input  logic [NUM_BANKS-1:0][ladybird_pkg::DATA_W-1:0] bank_rdata_i,
  output ladybird_pkg::bus_rsp_t                         rsp_o
);

  import ladybird_pkg::*;

  rsp_tag_t          tag_q;
  logic [DATA_W-1:0] sel_rdata;
  logic              rd_ok;

  // ##################################################
  // Tag alignment
  // ##################################################

  // Bank data shows up one cycle after the decoder stage
  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      tag_q <= '0;
    end else begin
      tag_q <= tag_i;
    end
  end

  // ##################################################
  // Read data select and response register
  // ##################################################

  always_comb begin
    sel_rdata = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (int'(tag_q.bank) == b) begin
        sel_rdata = bank_rdata_i[b];
      end
    end
  end

  assign rd_ok = tag_q.valid & ~tag_q.err & tag_q.is_read;  // Writes answer zero

  always_ff @(posedge clk_i or negedge anrst_i) begin
    if (!anrst_i) begin
      rsp_o <= '0;
    end else begin
      rsp_o.valid <= tag_q.valid;
      rsp_o.err   <= tag_q.valid & tag_q.err;
      rsp_o.rdata <= rd_ok ? sel_rdata : '0;
    end
  end

endmodule

`default_nettype wire

// ==== ladybird_fabric_top.sv ====
`default_nettype none

module ladybird_fabric_top #(
  parameter int NUM_BANKS   = 4,
  parameter int BANK_ADDR_W = 4
) (
  input  logic                   clk_i,
  input  logic                   anrst_i,
  input  ladybird_pkg::bus_req_t req_i,
  output ladybird_pkg::bus_rsp_t rsp_o
);

  import ladybird_pkg::*;

  bank_req_t                        bank_req;
  logic [NUM_BANKS-1:0]             bank_sel;
  rsp_tag_t                         tag;
  logic [NUM_BANKS-1:0][DATA_W-1:0] bank_rdata;

  // ##################################################
  // Decode stage
  // ##################################################

  ladybird_addr_decoder #(
    .NUM_BANKS   (NUM_BANKS),
    .BANK_ADDR_W (BANK_ADDR_W)
  ) u_decoder (
    .clk_i      (clk_i),
    .anrst_i    (anrst_i),
    .req_i      (req_i),
    .bank_req_o (bank_req),
    .bank_sel_o (bank_sel),
    .tag_o      (tag)
  );

  // ##################################################
  // RAM banks
  // ##################################################

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    ladybird_ram_bank #(
      .BANK_ADDR_W (BANK_ADDR_W)
    ) u_bank (
      .clk_i      (clk_i),
      .anrst_i    (anrst_i),
      .sel_i      (bank_sel[i]),
      .bank_req_i (bank_req),    // Same request for every bank
      .rdata_o    (bank_rdata[i])
    );
  end

  ladybird_resp_collector #(
    .NUM_BANKS (NUM_BANKS)
  ) u_collector (
    .clk_i        (clk_i),
    .anrst_i      (anrst_i),
    .tag_i        (tag),
    .bank_rdata_i (bank_rdata),
    .rsp_o        (rsp_o)
  );

endmodule

`default_nettype wire

// ==== ladybird_fabric_chk.sv ====
`default_nettype none

module ladybird_fabric_chk #(
  parameter int NUM_BANKS = 4
) (
  input logic                   clk_i,
  input logic                   anrst_i,
  input ladybird_pkg::bus_req_t req_i,
  input ladybird_pkg::bus_rsp_t rsp_i,
  input logic [NUM_BANKS-1:0]   bank_sel_i,
  input ladybird_pkg::rsp_tag_t tag_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import ladybird_pkg::*;

  // ##################################################
  // Fabric timing and decode properties
  // ##################################################

  a_no_rsp_in_reset : assert property (@(posedge clk_i) !anrst_i |-> !rsp_i.valid)
    else $error("Response valid while reset is asserted");

  a_one_bank_sel : assert property (@(posedge clk_i) disable iff (!anrst_i)
    $onehot0(bank_sel_i))
    else $error("More than one bank select high");

  // Decoder, bank and response register stages
  a_rsp_follows_req : assert property (@(posedge clk_i) disable iff (!anrst_i)
    req_i.valid |-> ##3 rsp_i.valid)
    else $error("Request got no response three cycles later");

  a_rsp_has_req : assert property (@(posedge clk_i) disable iff (!anrst_i)
    rsp_i.valid |-> $past(req_i.valid, 3))
    else $error("Response without a request three cycles earlier");

  a_no_sel_on_err : assert property (@(posedge clk_i) disable iff (!anrst_i)
    (tag_i.valid && tag_i.err) |-> (bank_sel_i == '0))
    else $error("Bank selected for an erroneous address");

endmodule

bind ladybird_fabric_top ladybird_fabric_chk #(
  .NUM_BANKS (NUM_BANKS)
) u_fabric_chk (
  .clk_i      (clk_i),
  .anrst_i    (anrst_i),
  .req_i      (req_i),
  .rsp_i      (rsp_o),
  .bank_sel_i (bank_sel),
  .tag_i      (tag)
);

`default_nettype wire

// ==== tb_ladybird_fabric.sv ====
`default_nettype none

module tb_ladybird_fabric;

  timeunit 1ns;
  timeprecision 1ps;

  import ladybird_pkg::*;

  localparam int NUM_BANKS   = 4;  // DUT defaults
  localparam int BANK_ADDR_W = 4;
  localparam int DEPTH       = 2 ** BANK_ADDR_W;
  localparam int LATENCY     = 3;
  localparam int TIMEOUT     = 100;  // Cycles to wait for outstanding responses

  logic     clk_i;
  logic     anrst_i;
  bus_req_t req_i;
  bus_rsp_t rsp_o;

  logic [DATA_W-1:0] model [NUM_BANKS*DEPTH];  // All banks, bank major
  bus_rsp_t          exp_q [$];
  int                issue_q [$];
  int                cyc = 0;
  int                checks = 0;
  int                errors = 0;
  int                test_errors = 0;
  string             test_name;

  ladybird_fabric_top dut (
    .clk_i   (clk_i),
    .anrst_i (anrst_i),
    .req_i   (req_i),
    .rsp_o   (rsp_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;  // Rising edges seen so far

  // ##################################################
  // Reference model and stimulus helpers
  // ##################################################

  function automatic bus_rsp_t ref_rsp(bus_req_t req);
    bus_rsp_t rsp;
    int       slot;
    rsp       = '0;
    rsp.valid = 1'b1;
    if (req.addr.fields.region != RAM_REGION || int'(req.addr.fields.bank) >= NUM_BANKS ||
        int'(req.addr.fields.index) >= DEPTH || req.addr.fields.byte_off != 2'b00) begin
      rsp.err = 1'b1;  // Banks untouched
    end else begin
      slot = int'(req.addr.fields.bank) * DEPTH + int'(req.addr.fields.index);
      if (req.we) begin
        for (int lane = 0; lane < STRB_W; lane++) begin
          if (req.strb[lane]) model[slot][8*lane +: 8] = req.wdata[8*lane +: 8];
        end
      end else begin
        rsp.rdata = model[slot];
      end
    end
    return rsp;
  endfunction

  function automatic bus_req_t make_req(logic we, bus_addr_u addr, logic [DATA_W-1:0] wdata,
                                        logic [STRB_W-1:0] strb);
    bus_req_t r;
    r.valid = 1'b1;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    r.strb  = strb;
    return r;
  endfunction

  function automatic bus_addr_u legal_addr(int bank, int word);
    bus_addr_u a;
    a.raw             = $urandom;  // Reserved bits stay random
    a.fields.region   = RAM_REGION;
    a.fields.bank     = bank[BANK_FIELD_W-1:0];
    a.fields.index    = word[INDEX_FIELD_W-1:0];
    a.fields.byte_off = 2'b00;
    return a;
  endfunction

  function automatic bus_addr_u rand_addr();
    return legal_addr($urandom_range(NUM_BANKS-1), $urandom_range(DEPTH-1));
  endfunction

  // Breaks exactly one of the four address rules
  function automatic bus_addr_u corrupt_addr(bus_addr_u a, int kind);
    bus_addr_u b;
    b = a;
    case (kind)
      0:       b.fields.region = a.fields.region ^ 4'($urandom_range(15, 1));
      1:       b.fields.bank = 4'(NUM_BANKS + $urandom_range(15 - NUM_BANKS));
      2:       b.fields.index[BANK_ADDR_W + $urandom_range(INDEX_FIELD_W-BANK_ADDR_W-1)] = 1'b1;
      default: b.fields.byte_off = 2'($urandom_range(3, 1));
    endcase
    return b;
  endfunction

  task automatic send(bus_req_t r);
    @(posedge clk_i);
    req_i <= r;
    exp_q.push_back(ref_rsp(r));
  endtask

  task automatic idle();
    @(posedge clk_i);
    req_i <= '0;
  endtask

  task automatic start_test(string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    int waited;
    waited = 0;
    idle();
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%s: gave up waiting for %0d responses", test_name, exp_q.size());
      errors++;
      test_errors++;
      exp_q.delete();
      issue_q.delete();
    end
    if (test_errors == 0) $display("%s: ok", test_name);
    else $display("%s: %0d errors", test_name, test_errors);
  endtask

  // ##################################################
  // Response compare
  // ##################################################

  task automatic check_rsp(bus_rsp_t exp, bus_rsp_t act);
    checks++;
    if (act !== exp) begin
      $display("Fail %s: expected valid=%0b err=%0b rdata=%08h, actual valid=%0b err=%0b rdata=%08h",
               test_name, exp.valid, exp.err, exp.rdata, act.valid, act.err, act.rdata);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_latency(int lat);
    checks++;
    if (lat != LATENCY) begin
      $display("Fail %s: expected latency %0d, actual latency %0d", test_name, LATENCY, lat);
      errors++;
      test_errors++;
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (req_i.valid) issue_q.push_back(cyc);  // Edge that launched it
    if (rsp_o.valid) begin
      if (exp_q.size() == 0 || issue_q.size() == 0) begin
        $display("%s: response arrived with no request outstanding", test_name);
        errors++;
        test_errors++;
      end else begin
        check_rsp(exp_q.pop_front(), rsp_o);
        check_latency(cyc - issue_q.pop_front());
      end
    end
  end

  // ##################################################
  // Test sequence
  // ##################################################

  initial begin
    bus_addr_u addrs [16];
    bus_addr_u a;
    int        r;
    void'($urandom(32'ha0cb00c0));
    clk_i   = 1'b0;
    anrst_i = 1'b0;
    req_i   = '0;
    foreach (model[i]) model[i] = '0;
    repeat (16) @(posedge clk_i);
    anrst_i <= 1'b1;

    start_test("reset_zero");
    for (int b = 0; b < NUM_BANKS; b++) begin
      repeat (4) send(make_req(1'b0, legal_addr(b, $urandom_range(DEPTH-1)), '0, '0));
    end
    finish_test();

    start_test("full_word");
    for (int i = 0; i < 16; i++) begin
      addrs[i] = legal_addr(i % NUM_BANKS, $urandom_range(DEPTH-1));
      send(make_req(1'b1, addrs[i], $urandom, 4'hf));
    end
    for (int i = 0; i < 16; i++) send(make_req(1'b0, addrs[i], '0, '0));
    finish_test();

    start_test("byte_strobe");
    for (int i = 0; i < 16; i++) begin
      addrs[i] = rand_addr();
      send(make_req(1'b1, addrs[i], $urandom, 4'($urandom_range(15))));
    end
    for (int i = 0; i < 16; i++) send(make_req(1'b0, addrs[i], '0, '0));
    finish_test();

    start_test("read_after_write");
    repeat (8) begin
      a = rand_addr();
      send(make_req(1'b1, a, $urandom, 4'($urandom_range(15, 1))));
      send(make_req(1'b0, a, '0, '0));
    end
    finish_test();

    start_test("addr_error");
    for (int kind = 0; kind < 4; kind++) begin
      a = rand_addr();
      send(make_req(1'b1, a, $urandom, 4'hf));
      send(make_req(1'b1, corrupt_addr(a, kind), $urandom, 4'hf));
      send(make_req(1'b0, corrupt_addr(a, kind), '0, '0));
      send(make_req(1'b0, a, '0, '0));  // Target word unchanged
    end
    finish_test();

    start_test("random_mix");
    repeat (200) begin
      r = $urandom_range(9);
      if (r < 2) idle();
      else if (r == 2) send(make_req(1'($urandom), corrupt_addr(rand_addr(), $urandom_range(3)),
                                     $urandom, 4'($urandom)));
      else send(make_req(1'($urandom), rand_addr(), $urandom, 4'($urandom)));
    end
    finish_test();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
ladybird_pkg.sv
ladybird_addr_decoder.sv
ladybird_ram_bank.sv
ladybird_resp_collector.sv
ladybird_fabric_top.sv
ladybird_fabric_chk.sv
tb_ladybird_fabric.sv

// ==== Bender.yml ====
package:
  name: ladybird_fabric

sources:
  # Synthesizable fabric, package first
  - files:
      - ladybird_pkg.sv
      - ladybird_addr_decoder.sv
      - ladybird_ram_bank.sv
      - ladybird_resp_collector.sv
      - ladybird_fabric_top.sv

  # Simulation only
  - target: test
    files:
      - ladybird_fabric_chk.sv
      - tb_ladybird_fabric.sv
